//--- common/block_sync_pkg.sv
package block_sync_pkg;

    // coded block geometry
    localparam int NB_CODED_BLOCK = 66;
    localparam int NB_PAYLOAD     = 64;
    localparam int NB_SH          = NB_CODED_BLOCK - NB_PAYLOAD;

    // config field widths
    localparam int NB_SYNC_TIMER  = 11;
    localparam int NB_SH_INVALID  = 3;

    // bit 0 is the first bit on the line
    // [1:0] sync header, [65:2] payload
    typedef logic [NB_CODED_BLOCK-1:0] coded_block_t;

    // the only two legal sync headers
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // runtime limits, static once out of reset
    typedef struct packed {
        logic [NB_SYNC_TIMER-1:0] unlocked_timer_limit; // good headers in a row to lock
        logic [NB_SYNC_TIMER-1:0] locked_timer_limit;   // checking window length
        logic [NB_SH_INVALID-1:0] sh_invalid_limit;     // bad headers per window
    } sync_cfg_t;

    // aligned block plus status flags
    typedef struct packed {
        logic                  block_lock;
        logic                  sh_valid;
        logic [NB_SH-1:0]      header;
        logic [NB_PAYLOAD-1:0] payload;
    } rx_block_t;

endpackage

//--- block_sync/block_sync_fsm.sv
`timescale 1ns/1ps

module block_sync_fsm
#(
    parameter int NB_CODED_BLOCK = block_sync_pkg::NB_CODED_BLOCK,
    parameter int MAX_WINDOW     = 2048
)
(
    input  logic                              i_clock,
    input  logic                              i_rst,
    input  logic                              i_enable,
    input  logic                              i_valid,
    input  logic                              i_signal_ok,
    input  logic                              i_sh_valid,
    input  block_sync_pkg::sync_cfg_t         i_cfg,
    output logic [$clog2(NB_CODED_BLOCK)-1:0] o_search_index,
    output logic [$clog2(NB_CODED_BLOCK)-1:0] o_block_index,
    output logic                              o_block_lock
);

    import block_sync_pkg::*;

    localparam int NB_INDEX = $clog2(NB_CODED_BLOCK);
    localparam int NB_TIMER = $clog2(MAX_WINDOW);

    // one-hot states
    localparam logic [1:0] UNLOCKED = 2'b01;
    localparam logic [1:0] LOCKED   = 2'b10;

    localparam logic [NB_INDEX-1:0] LAST_INDEX = NB_INDEX'(NB_CODED_BLOCK - 1);

    logic [1:0]               state;
    logic [1:0]               next_state;
    logic [NB_INDEX-1:0]      search_index;
    logic [NB_INDEX-1:0]      next_search_index;
    logic [NB_INDEX-1:0]      block_index;
    logic [NB_INDEX-1:0]      next_block_index;
    logic [NB_TIMER-1:0]      timer;
    logic [NB_TIMER-1:0]      next_timer;
    logic [NB_TIMER-1:0]      timer_inc;
    logic [NB_TIMER-1:0]      unlocked_limit;
    logic [NB_TIMER-1:0]      locked_limit;
    logic [NB_SH_INVALID-1:0] sh_invalid_count;
    logic [NB_SH_INVALID-1:0] next_sh_invalid_count;
    logic [NB_SH_INVALID-1:0] count_inc;
    logic                     step;

    assign step           = i_enable && i_valid;
    assign unlocked_limit = NB_TIMER'(i_cfg.unlocked_timer_limit);
    assign locked_limit   = NB_TIMER'(i_cfg.locked_timer_limit);
    assign timer_inc      = timer + 1'b1;
    assign count_inc      = sh_invalid_count + NB_SH_INVALID'(!i_sh_valid); // bad headers so far

    always_comb
    begin
        next_state            = state;
        next_search_index     = search_index;
        next_block_index      = block_index;
        next_timer            = timer;
        next_sh_invalid_count = sh_invalid_count;

        case (state)
            UNLOCKED:
            begin
                if (!i_sh_valid)
                begin
                    // slip one bit and start counting again
                    next_timer            = '0;
                    next_sh_invalid_count = '0;
                    next_search_index     = (search_index == LAST_INDEX) ? '0
                                                                         : search_index + 1'b1;
                end
                else if (timer_inc == unlocked_limit)
                begin
                    next_timer            = '0;
                    next_sh_invalid_count = '0;
                    next_block_index      = search_index; // lock onto this offset
                    next_state            = LOCKED;
                end
                else
                begin
                    next_timer = timer_inc;
                end
            end

            LOCKED:
            begin
                if (count_inc >= i_cfg.sh_invalid_limit)
                begin
                    next_timer            = '0;
                    next_sh_invalid_count = '0;
                    next_search_index     = '0; // restart search from offset 0
                    next_state            = UNLOCKED;
                end
                else if (timer_inc == locked_limit)
                begin
                    next_timer            = '0; // new window
                    next_sh_invalid_count = '0;
                end
                else
                begin
                    next_timer            = timer_inc;
                    next_sh_invalid_count = count_inc;
                end
            end

            default:
            begin
                next_state = UNLOCKED;
            end
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst || !i_signal_ok) // signal loss drops lock without waiting for valid
        begin
            state            <= UNLOCKED;
            search_index     <= '0;
            block_index      <= '0;
            timer            <= '0;
            sh_invalid_count <= '0;
        end
        else if (step)
        begin
            state            <= next_state;
            search_index     <= next_search_index;
            block_index      <= next_block_index;
            timer            <= next_timer;
            sh_invalid_count <= next_sh_invalid_count;
        end
    end

    assign o_search_index = search_index;
    assign o_block_index  = block_index;
    assign o_block_lock   = (state == LOCKED);

    // lock only follows a good header seen at the previous edge
    a_lock_needs_sh: assert property (@(posedge i_clock) disable iff (i_rst)
        $rose(o_block_lock) |-> $past(i_sh_valid && step));

    a_search_in_range: assert property (@(posedge i_clock) disable iff (i_rst)
        search_index < NB_CODED_BLOCK);

endmodule

//--- block_sync/block_aligner.sv
`timescale 1ns/1ps

module block_aligner
#(
    parameter int NB_CODED_BLOCK = block_sync_pkg::NB_CODED_BLOCK
)
(
    input  logic                              i_clock,
    input  logic                              i_rst,
    input  logic                              i_valid,
    input  block_sync_pkg::coded_block_t      i_word,
    input  logic [$clog2(NB_CODED_BLOCK)-1:0] i_search_index,
    input  logic [$clog2(NB_CODED_BLOCK)-1:0] i_block_index,
    input  logic                              i_block_lock,
    output logic                              o_sh_valid,
    output block_sync_pkg::rx_block_t         o_block,
    output logic                              o_valid
);

    import block_sync_pkg::*;

    localparam int NB_WINDOW = 2 * NB_CODED_BLOCK;

    coded_block_t         prev_word;
    logic [NB_WINDOW-1:0] window;
    logic [NB_SH-1:0]     search_header;
    coded_block_t         block;
    logic                 block_sh_ok;
    rx_block_t            block_reg;
    logic                 valid_reg;

    // older word sits in the low half, its bits went out first
    assign window = {i_word, prev_word};

    assign search_header = window[i_search_index +: NB_SH];
    assign block         = window[i_block_index +: NB_CODED_BLOCK];
    assign block_sh_ok   = (block[NB_SH-1:0] == SH_DATA) || (block[NB_SH-1:0] == SH_CTRL);

    // feeds the lock FSM in the same cycle
    assign o_sh_valid = i_valid && ((search_header == SH_DATA) || (search_header == SH_CTRL));

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            prev_word <= i_word;
        end
    end

    // payload register, no reset
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            block_reg.block_lock <= i_block_lock; // lock state at extraction time
            block_reg.sh_valid   <= block_sh_ok;
            block_reg.header     <= block[NB_SH-1:0];
            block_reg.payload    <= block[NB_CODED_BLOCK-1:NB_SH];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            valid_reg <= 1'b0;
        end
        else
        begin
            valid_reg <= i_valid;
        end
    end

    assign o_block = block_reg;
    assign o_valid = valid_reg;

    // block offset must leave a whole block inside the window
    a_block_index_in_window: assert property (@(posedge i_clock) disable iff (i_rst)
        i_valid |-> (i_block_index < NB_CODED_BLOCK));

endmodule

//--- verilog/descrambler.sv
`timescale 1ns/1ps

module descrambler
(
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_valid,
    input  block_sync_pkg::rx_block_t i_block,
    output block_sync_pkg::rx_block_t o_block,
    output logic                      o_valid
);

    import block_sync_pkg::*;

    localparam int NB_HIST = 58; // x^58 + x^39 + 1

    logic [NB_HIST-1:0]    scr_hist;  // bit 0 is the newest scrambled bit
    logic [NB_HIST-1:0]    walk_hist;
    logic [NB_PAYLOAD-1:0] plain;
    rx_block_t             block_reg;
    logic                  valid_reg;

    // bit serial descramble, payload bit 0 (block bit 2) first
    always_comb
    begin
        walk_hist = scr_hist;
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            plain[i]  = i_block.payload[i] ^ walk_hist[38] ^ walk_hist[57];
            walk_hist = {walk_hist[NB_HIST-2:0], i_block.payload[i]};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            scr_hist  <= '0;
            valid_reg <= 1'b0;
        end
        else
        begin
            valid_reg <= i_valid;
            if (i_valid)
            begin
                scr_hist <= i_block.block_lock ? walk_hist : '0; // flush while unlocked
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            block_reg         <= i_block; // header and flags pass through
            block_reg.payload <= plain;
        end
    end

    assign o_block = block_reg;
    assign o_valid = valid_reg;

endmodule

//--- verilog/pcs_rx_sync_top.sv
`timescale 1ns/1ps

module pcs_rx_sync_top
#(
    parameter int NB_CODED_BLOCK = block_sync_pkg::NB_CODED_BLOCK,
    parameter int MAX_WINDOW     = 2048
)
(
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_enable,
    input  logic                         i_valid,
    input  logic                         i_signal_ok,
    input  block_sync_pkg::coded_block_t i_word,
    input  block_sync_pkg::sync_cfg_t    i_cfg,
    output block_sync_pkg::rx_block_t    o_block,
    output logic                         o_valid,
    output logic                         o_block_lock
);

    import block_sync_pkg::*;

    localparam int NB_INDEX = $clog2(NB_CODED_BLOCK);

    logic                word_valid;
    logic                sh_valid;
    logic [NB_INDEX-1:0] search_index;
    logic [NB_INDEX-1:0] block_index;
    logic                block_lock;
    rx_block_t           aligned_block;
    logic                aligned_valid;

    // words only count while enabled
    assign word_valid = i_valid && i_enable;

    block_aligner
    #(
        .NB_CODED_BLOCK (NB_CODED_BLOCK)
    )
    u_block_aligner
    (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_valid        (word_valid),
        .i_word         (i_word),
        .i_search_index (search_index),
        .i_block_index  (block_index),
        .i_block_lock   (block_lock),
        .o_sh_valid     (sh_valid),
        .o_block        (aligned_block),
        .o_valid        (aligned_valid)
    );

    block_sync_fsm
    #(
        .NB_CODED_BLOCK (NB_CODED_BLOCK),
        .MAX_WINDOW     (MAX_WINDOW)
    )
    u_block_sync_fsm
    (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_enable       (i_enable),
        .i_valid        (i_valid),
        .i_signal_ok    (i_signal_ok),
        .i_sh_valid     (sh_valid),
        .i_cfg          (i_cfg),
        .o_search_index (search_index),
        .o_block_index  (block_index),
        .o_block_lock   (block_lock)
    );

    descrambler u_descrambler
    (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_valid (aligned_valid),
        .i_block (aligned_block),
        .o_block (o_block),
        .o_valid (o_valid)
    );

    assign o_block_lock = block_lock;

endmodule

//--- bench/tb_stream_model.svh
// x^58 + x^39 + 1 scrambler, payload bit 0 goes out first
// hist bit 0 is the newest scrambled bit
function automatic logic [63:0] scramble_payload(input logic [63:0] plain,
                                                 input logic [57:0] hist);
    logic [57:0] h;
    logic [63:0] scr;
    h = hist;
    for (int i = 0; i < 64; i++)
    begin
        scr[i] = plain[i] ^ h[38] ^ h[57];
        h      = {h[56:0], scr[i]};
    end
    return scr;
endfunction

function automatic logic [57:0] next_history(input logic [57:0] hist, input logic [63:0] scr);
    logic [57:0] h;
    h = hist;
    for (int i = 0; i < 64; i++)
    begin
        h = {h[56:0], scr[i]};
    end
    return h;
endfunction

function automatic logic header_is_valid(input logic [1:0] header);
    return (header == SH_DATA) || (header == SH_CTRL);
endfunction

// word n carries the tail of block n-1 in its low bits, then the head of block n
function automatic coded_block_t shift_word(input coded_block_t prev_blk,
                                            input coded_block_t cur_blk,
                                            input int bit_offset);
    logic [2*NB_CODED_BLOCK-1:0] pair;
    pair = {cur_blk, prev_blk} >> (NB_CODED_BLOCK - bit_offset);
    return pair[NB_CODED_BLOCK-1:0];
endfunction

//--- bench/tb_pcs_rx_sync.sv
`timescale 1ns/1ps

module tb_pcs_rx_sync;

    import block_sync_pkg::*;

    `include "tb_stream_model.svh"

    localparam int BIT_OFFSET    = 27;
    localparam int LOCK_BOUND    = 66 * (64 + 1) + 2;
    localparam int FIXED_WORDS   = 257; // every word sent outside the lock searches
    localparam int MAX_WORDS     = 3 * LOCK_BOUND + FIXED_WORDS;
    localparam int TIMEOUT_LIMIT = MAX_WORDS * 4 + 100;

    logic         i_clock;
    logic         i_rst;
    logic         i_enable;
    logic         i_valid;
    logic         i_signal_ok;
    coded_block_t i_word;
    sync_cfg_t    i_cfg;
    rx_block_t    o_block;
    logic         o_valid;
    logic         o_block_lock;

    integer       seed;
    int           cycle_count;
    int           locked_run;
    coded_block_t prev_block;
    logic [63:0]  prev_plain;
    logic [57:0]  tx_hist;
    rx_block_t    exp_blk;
    bit           exp_known;
    rx_block_t    expected_q[$];
    bit           known_q[$];

    pcs_rx_sync_top
    #(
        .NB_CODED_BLOCK (NB_CODED_BLOCK),
        .MAX_WINDOW     (2048)
    )
    dut0
    (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_enable     (i_enable),
        .i_valid      (i_valid),
        .i_signal_ok  (i_signal_ok),
        .i_word       (i_word),
        .i_cfg        (i_cfg),
        .o_block      (o_block),
        .o_valid      (o_valid),
        .o_block_lock (o_block_lock)
    );

    always #50 i_clock = ~i_clock;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    endtask

    // what the DUT must deliver for a block, payload back in the clear
    function automatic rx_block_t expected_block(input coded_block_t blk,
                                                 input logic [63:0] plain,
                                                 input logic lock_flag);
        rx_block_t eb;
        eb.block_lock = lock_flag;
        eb.sh_valid   = header_is_valid(blk[1:0]);
        eb.header     = blk[1:0];
        eb.payload    = plain;
        return eb;
    endfunction

    task automatic send_words(input int count, input logic bad_header, input bit lock_known,
                              input logic lock_flag);
        coded_block_t cur;
        logic [63:0]  plain;
        logic [1:0]   header;
        for (int n = 0; n < count; n++)
        begin
            plain  = {$random(seed), $random(seed)};
            header = ($random(seed) & 1) ? SH_CTRL : SH_DATA;
            if (bad_header)
            begin
                header = {header[0], header[0]}; // 00 or 11
            end
            cur = {scramble_payload(plain, tx_hist), header};
            @(negedge i_clock);
            i_word  = shift_word(prev_block, cur, BIT_OFFSET);
            i_valid = 1'b1;
            // completed by this word
            expected_q.push_back(expected_block(prev_block, prev_plain, lock_flag));
            known_q.push_back(lock_known);
            tx_hist    = next_history(tx_hist, cur[65:2]);
            prev_plain = plain;
            prev_block = cur;
        end
    endtask

    task automatic send_until_lock();
        int sent;
        sent = 0;
        while (o_block_lock !== 1'b1 && sent < LOCK_BOUND)
        begin
            send_words(1, 1'b0, 1'b0, 1'b0);
            sent++;
        end
        assert (o_block_lock === 1'b1)
        else abort_run($sformatf("block lock not acquired within %0d words", LOCK_BOUND));
    endtask

    always @(posedge i_clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_LIMIT)
        begin
            abort_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    always @(negedge i_clock)
    begin
        if (!i_rst && o_valid === 1'b1)
        begin
            assert (expected_q.size() > 0)
            else abort_run("output strobe arrived with no block pending");
            exp_blk   = expected_q.pop_front();
            exp_known = known_q.pop_front();
            if (o_block.block_lock === 1'b1)
            begin
                locked_run++;
            end
            else
            begin
                locked_run = 0;
            end
            if (exp_known)
            begin
                check_value("output block_lock", exp_blk.block_lock, o_block.block_lock);
            end
            if (o_block.block_lock === 1'b1)
            begin
                check_value("alignment header", exp_blk.header, o_block.header);
                check_value("alignment sh_valid", exp_blk.sh_valid, o_block.sh_valid);
                if (locked_run >= 2) // first locked block still fills the history
                begin
                    check_value("descrambling payload", exp_blk.payload, o_block.payload);
                end
            end
        end
    end

    initial
    begin
        seed        = 32'hd904bca4;
        i_clock     = 1'b0;
        i_rst       = 1'b1;
        i_enable    = 1'b1;
        i_valid     = 1'b0;
        i_signal_ok = 1'b1;
        i_word      = '0;
        i_cfg.unlocked_timer_limit = 11'd64;
        i_cfg.locked_timer_limit   = 11'd64;
        i_cfg.sh_invalid_limit     = 3'd4;
        cycle_count = 0;
        locked_run  = 0;
        prev_block  = '0;
        prev_plain  = '0;
        tx_hist     = '0;
        repeat (10) @(negedge i_clock);
        i_rst = 1'b0;

        send_until_lock();
        // bad headers land at window edges 10..12, then 74..77
        send_words(7, 1'b0, 1'b1, 1'b1);
        send_words(3, 1'b1, 1'b1, 1'b1);
        send_words(61, 1'b0, 1'b1, 1'b1);
        check_value("tolerance block_lock", 1, o_block_lock);
        send_words(4, 1'b1, 1'b1, 1'b1);
        send_words(1, 1'b0, 1'b1, 1'b1); // taken at the edge that drops lock
        send_words(1, 1'b0, 1'b1, 1'b0);
        check_value("tolerance block_lock", 0, o_block_lock);
        send_until_lock();
        send_words(100, 1'b0, 1'b1, 1'b1);

        i_signal_ok = 1'b0;
        @(negedge i_clock);
        i_valid = 1'b0;
        check_value("signal_loss block_lock", 0, o_block_lock);
        i_signal_ok = 1'b1;
        send_words(60, 1'b0, 1'b1, 1'b0); // too few to lock again
        send_until_lock();
        send_words(20, 1'b0, 1'b1, 1'b1);

        @(negedge i_clock);
        i_valid = 1'b0;
        repeat (4) @(negedge i_clock);
        if (expected_q.size() == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            abort_run($sformatf("%0d blocks never came out", expected_q.size()));
        end
    end

endmodule

//--- project.f
+incdir+bench
common/block_sync_pkg.sv
block_sync/block_sync_fsm.sv
block_sync/block_aligner.sv
verilog/descrambler.sv
verilog/pcs_rx_sync_top.sv
bench/tb_pcs_rx_sync.sv
